//--- src/rv_consts.svh
`ifndef RV_CONSTS_SVH
`define RV_CONSTS_SVH

// architectural word width.
`define RV_XLEN 32

// integer register file size, x0 included.
`define RV_NREGS 32

// local instruction memory, in 32-bit words.
`define RV_IMEM_WORDS 256
`define RV_IMEM_AW 8

`endif

//--- src/rv_isa_pkg.sv
`include "rv_consts.svh"

package rv_isa_pkg;

    typedef logic [`RV_XLEN-1:0] word_t;
    typedef logic [$clog2(`RV_NREGS)-1:0] reg_addr_t;
    typedef logic [2:0] funct3_t;
    typedef logic [6:0] funct7_t;

    // only the opcodes this core executes.
    typedef enum logic [6:0] {
        OPC_OP     = 7'b0110011,
        OPC_OP_IMM = 7'b0010011,
        OPC_LUI    = 7'b0110111,
        OPC_AUIPC  = 7'b0010111,
        OPC_JAL    = 7'b1101111,
        OPC_JALR   = 7'b1100111,
        OPC_BRANCH = 7'b1100011
    } opcode_e;

    // funct3 for OP and OP_IMM.
    localparam funct3_t F3_ADD  = 3'b000;
    localparam funct3_t F3_SLL  = 3'b001;
    localparam funct3_t F3_SLT  = 3'b010;
    localparam funct3_t F3_SLTU = 3'b011;
    localparam funct3_t F3_XOR  = 3'b100;
    localparam funct3_t F3_SR   = 3'b101;
    localparam funct3_t F3_OR   = 3'b110;
    localparam funct3_t F3_AND  = 3'b111;

    // funct3 for BRANCH.
    localparam funct3_t F3_BEQ  = 3'b000;
    localparam funct3_t F3_BNE  = 3'b001;
    localparam funct3_t F3_BLT  = 3'b100;
    localparam funct3_t F3_BGE  = 3'b101;
    localparam funct3_t F3_BLTU = 3'b110;
    localparam funct3_t F3_BGEU = 3'b111;

    // sub and sra select.
    localparam funct7_t F7_ALT  = 7'b0100000;

endpackage

//--- src/rv_pipe_pkg.sv
package rv_pipe_pkg;

    typedef enum logic [3:0] {
        ALU_ADD,
        ALU_SUB,
        ALU_SLL,
        ALU_SLT,
        ALU_SLTU,
        ALU_XOR,
        ALU_SRL,
        ALU_SRA,
        ALU_OR,
        ALU_AND
    } alu_op_e;

    typedef enum logic [1:0] {
        KIND_ALU,
        KIND_BRANCH,
        KIND_JUMP
    } ctrl_kind_e;

    // operand a source.
    typedef enum logic [1:0] {
        SRC_RS1,
        SRC_PC,
        SRC_ZERO
    } src_sel_e;

endpackage

//--- src/id_ex_if.sv
`timescale 1ns/1ps

interface id_ex_if;
    import rv_isa_pkg::*;
    import rv_pipe_pkg::*;

    logic       valid;
    word_t      pc;
    word_t      op1;
    word_t      op2;
    word_t      imm;
    alu_op_e    alu_op;
    src_sel_e   a_sel;
    logic       use_imm;
    ctrl_kind_e kind;
    funct3_t    funct3;
    logic       wb_en;
    reg_addr_t  rd;

    modport producer (
        output valid, pc, op1, op2, imm, alu_op, a_sel, use_imm,
        output kind, funct3, wb_en, rd
    );

    modport consumer (
        input valid, pc, op1, op2, imm, alu_op, a_sel, use_imm,
        input kind, funct3, wb_en, rd
    );

endinterface

//--- src/fetch_stage.sv
`timescale 1ns/1ps
`include "rv_consts.svh"

module fetch_stage (
    input  logic                   clk,
    input  logic                   rst,
    input  logic                   run,
    input  logic                   advance,
    input  logic                   redirect,
    input  rv_isa_pkg::word_t      redirect_pc,
    input  logic                   imem_we,
    input  logic [`RV_IMEM_AW-1:0] imem_addr,
    input  rv_isa_pkg::word_t      imem_wdata,
    output logic                   if_valid,
    output rv_isa_pkg::word_t      if_pc,
    output rv_isa_pkg::word_t      if_instr
);
    import rv_isa_pkg::*;

    word_t imem [`RV_IMEM_WORDS];
    word_t pc;

    // program load port, closed once running.
    always_ff @(posedge clk) begin
        if (imem_we && !run) begin
            imem[imem_addr] <= imem_wdata;
        end
    end

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            pc       <= '0;
            if_valid <= 1'b0;
        end else if (!run) begin
            pc       <= '0;
            if_valid <= 1'b0;
        end else if (advance) begin
            if (redirect) begin
                // wrong-path word is dropped.
                pc       <= redirect_pc;
                if_valid <= 1'b0;
            end else begin
                pc       <= pc + 32'd4;
                if_valid <= 1'b1;
            end
        end
    end

    always_ff @(posedge clk) begin
        if (run && advance) begin
            if_pc    <= pc;
            if_instr <= imem[pc[(`RV_IMEM_AW + 1):2]];
        end
    end

endmodule

//--- src/decode_stage.sv
`timescale 1ns/1ps
`include "rv_consts.svh"

module decode_stage (
    input  logic                  clk,
    input  logic                  rst,
    input  logic                  advance,
    input  logic                  if_valid,
    input  rv_isa_pkg::word_t     if_pc,
    input  rv_isa_pkg::word_t     if_instr,
    input  logic                  fwd_en,
    input  rv_isa_pkg::reg_addr_t fwd_rd,
    input  rv_isa_pkg::word_t     fwd_data,
    input  logic                  wb_en,
    input  rv_isa_pkg::reg_addr_t wb_rd,
    input  rv_isa_pkg::word_t     wb_data,
    id_ex_if.producer             dec_bus
);
    import rv_isa_pkg::*;
    import rv_pipe_pkg::*;

    word_t      regs [`RV_NREGS];
    opcode_e    opcode;
    funct3_t    funct3;
    funct7_t    funct7;
    reg_addr_t  rd;
    reg_addr_t  rs1;
    reg_addr_t  rs2;
    word_t      imm;
    alu_op_e    alu_op;
    src_sel_e   a_sel;
    logic       use_imm;
    ctrl_kind_e kind;
    logic       writes;

    assign opcode = opcode_e'(if_instr[6:0]);
    assign rd     = if_instr[11:7];
    assign funct3 = if_instr[14:12];
    assign rs1    = if_instr[19:15];
    assign rs2    = if_instr[24:20];
    assign funct7 = if_instr[31:25];

    function automatic alu_op_e alu_from_f3(funct3_t f3, logic alt);
        alu_op_e op;
        op = ALU_ADD;
        case (f3)
            F3_ADD:  op = alt ? ALU_SUB : ALU_ADD;
            F3_SLL:  op = ALU_SLL;
            F3_SLT:  op = ALU_SLT;
            F3_SLTU: op = ALU_SLTU;
            F3_XOR:  op = ALU_XOR;
            F3_SR:   op = alt ? ALU_SRA : ALU_SRL;
            F3_OR:   op = ALU_OR;
            F3_AND:  op = ALU_AND;
        endcase
        return op;
    endfunction

    // newest producer wins. x0 never matches.
    function automatic word_t bypass(reg_addr_t rs);
        word_t val;
        val = (rs == '0) ? '0 : regs[rs];
        if (wb_en && wb_rd == rs && rs != '0) begin
            val = wb_data;
        end
        if (fwd_en && fwd_rd == rs && rs != '0) begin
            val = fwd_data;
        end
        return val;
    endfunction

    always_comb begin
        imm     = '0;
        alu_op  = ALU_ADD;
        a_sel   = SRC_RS1;
        use_imm = 1'b0;
        kind    = KIND_ALU;
        writes  = 1'b0;
        case (opcode)
            OPC_OP: begin
                alu_op = alu_from_f3(funct3, funct7 == F7_ALT);
                writes = 1'b1;
            end
            OPC_OP_IMM: begin
                imm     = {{20{if_instr[31]}}, if_instr[31:20]};
                alu_op  = alu_from_f3(funct3, funct3 == F3_SR && funct7 == F7_ALT);
                use_imm = 1'b1;
                writes  = 1'b1;
            end
            OPC_LUI, OPC_AUIPC: begin
                imm     = {if_instr[31:12], 12'b0};
                a_sel   = (opcode == OPC_LUI) ? SRC_ZERO : SRC_PC;
                use_imm = 1'b1;
                writes  = 1'b1;
            end
            OPC_JAL: begin
                imm    = {{12{if_instr[31]}}, if_instr[19:12], if_instr[20],
                          if_instr[30:21], 1'b0};
                a_sel  = SRC_PC;
                kind   = KIND_JUMP;
                writes = 1'b1;
            end
            OPC_JALR: begin
                imm    = {{20{if_instr[31]}}, if_instr[31:20]};
                kind   = KIND_JUMP;
                writes = 1'b1;
            end
            OPC_BRANCH: begin
                imm  = {{20{if_instr[31]}}, if_instr[7], if_instr[30:25],
                        if_instr[11:8], 1'b0};
                kind = KIND_BRANCH;
            end
            default: ;
        endcase
    end

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            for (int i = 0; i < `RV_NREGS; i++) begin
                regs[i] <= '0;
            end
        end else if (advance && wb_en && wb_rd != '0) begin
            regs[wb_rd] <= wb_data;
        end
    end

    // operands follow the register file and both bypass sources.
    always_comb begin
        dec_bus.op1 = bypass(rs1);
        dec_bus.op2 = bypass(rs2);
    end

    assign dec_bus.valid   = if_valid;
    assign dec_bus.pc      = if_pc;
    assign dec_bus.imm     = imm;
    assign dec_bus.alu_op  = alu_op;
    assign dec_bus.a_sel   = a_sel;
    assign dec_bus.use_imm = use_imm;
    assign dec_bus.kind    = kind;
    assign dec_bus.funct3  = funct3;
    assign dec_bus.wb_en   = if_valid && writes && rd != '0;
    assign dec_bus.rd      = rd;

endmodule

//--- src/id_ex_pipeline.sv
`timescale 1ns/1ps

module id_ex_pipeline (
    input  logic      clk,
    input  logic      rst,
    input  logic      advance,
    input  logic      redirect,
    id_ex_if.consumer dec_bus,
    id_ex_if.producer ex_bus
);

    // a flush leaves a bubble with no register write.
    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            ex_bus.valid <= 1'b0;
            ex_bus.wb_en <= 1'b0;
        end else if (redirect) begin
            ex_bus.valid <= 1'b0;
            ex_bus.wb_en <= 1'b0;
        end else if (advance) begin
            ex_bus.valid <= dec_bus.valid;
            ex_bus.wb_en <= dec_bus.wb_en;
        end
    end

    always_ff @(posedge clk) begin
        if (advance) begin
            ex_bus.pc      <= dec_bus.pc;
            ex_bus.op1     <= dec_bus.op1;
            ex_bus.op2     <= dec_bus.op2;
            ex_bus.imm     <= dec_bus.imm;
            ex_bus.alu_op  <= dec_bus.alu_op;
            ex_bus.a_sel   <= dec_bus.a_sel;
            ex_bus.use_imm <= dec_bus.use_imm;
            ex_bus.kind    <= dec_bus.kind;
            ex_bus.funct3  <= dec_bus.funct3;
            ex_bus.rd      <= dec_bus.rd;
        end
    end

endmodule

//--- src/execute_stage.sv
`timescale 1ns/1ps

module execute_stage (
    input  logic                  clk,
    input  logic                  rst,
    id_ex_if.consumer             ex_bus,
    output logic                  redirect,
    output rv_isa_pkg::word_t     redirect_pc,
    output logic                  fwd_en,
    output rv_isa_pkg::reg_addr_t fwd_rd,
    output rv_isa_pkg::word_t     fwd_data,
    output logic                  wb_en,
    output rv_isa_pkg::reg_addr_t wb_rd,
    output rv_isa_pkg::word_t     wb_data,
    output logic                  advance,
    output logic                  retire_valid,
    input  logic                  retire_ready,
    output rv_isa_pkg::word_t     retire_pc,
    output rv_isa_pkg::reg_addr_t retire_rd,
    output rv_isa_pkg::word_t     retire_data
);
    import rv_isa_pkg::*;
    import rv_pipe_pkg::*;

    word_t a;
    word_t b;
    word_t alu_out;
    word_t result;
    word_t base;
    logic  eq;
    logic  lt;
    logic  ltu;
    logic  cond;
    logic  taken;
    logic  wb_we;

    always_comb begin
        case (ex_bus.a_sel)
            SRC_RS1: a = ex_bus.op1;
            SRC_PC:  a = ex_bus.pc;
            default: a = '0;
        endcase
        b = ex_bus.use_imm ? ex_bus.imm : ex_bus.op2;
        case (ex_bus.alu_op)
            ALU_SUB:  alu_out = a - b;
            ALU_SLL:  alu_out = a << b[4:0];
            ALU_SLT:  alu_out = {31'b0, $signed(a) < $signed(b)};
            ALU_SLTU: alu_out = {31'b0, a < b};
            ALU_XOR:  alu_out = a ^ b;
            ALU_SRL:  alu_out = a >> b[4:0];
            ALU_SRA:  alu_out = $signed(a) >>> b[4:0];
            ALU_OR:   alu_out = a | b;
            ALU_AND:  alu_out = a & b;
            default:  alu_out = a + b;
        endcase
    end

    // branch compare always on the register operands.
    assign eq  = ex_bus.op1 == ex_bus.op2;
    assign lt  = $signed(ex_bus.op1) < $signed(ex_bus.op2);
    assign ltu = ex_bus.op1 < ex_bus.op2;

    always_comb begin
        case (ex_bus.funct3)
            F3_BEQ:  cond = eq;
            F3_BNE:  cond = !eq;
            F3_BLT:  cond = lt;
            F3_BGE:  cond = !lt;
            F3_BLTU: cond = ltu;
            F3_BGEU: cond = !ltu;
            default: cond = 1'b0;
        endcase
    end

    assign taken = (ex_bus.kind == KIND_JUMP) || (ex_bus.kind == KIND_BRANCH && cond);

    // jalr is the only jump based on rs1.
    assign base        = (ex_bus.kind == KIND_JUMP && ex_bus.a_sel == SRC_RS1) ?
                         ex_bus.op1 : ex_bus.pc;
    assign redirect_pc = (base + ex_bus.imm) & ~32'd1;
    assign result      = (ex_bus.kind == KIND_JUMP) ? ex_bus.pc + 32'd4 : alu_out;

    assign advance  = !(retire_valid && !retire_ready);
    assign redirect = ex_bus.valid && taken && advance;

    assign fwd_en   = ex_bus.valid && ex_bus.wb_en;
    assign fwd_rd   = ex_bus.rd;
    assign fwd_data = result;

    // writeback register, also the retire slot.
    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            retire_valid <= 1'b0;
            wb_we        <= 1'b0;
        end else if (advance) begin
            retire_valid <= ex_bus.valid;
            wb_we        <= ex_bus.valid && ex_bus.wb_en;
        end
    end

    always_ff @(posedge clk) begin
        if (advance) begin
            retire_pc <= ex_bus.pc;
            wb_rd     <= ex_bus.rd;
            wb_data   <= result;
        end
    end

    assign wb_en       = wb_we;
    assign retire_rd   = wb_we ? wb_rd : '0;
    assign retire_data = wb_we ? wb_data : '0;

endmodule

//--- src/rv_int_core.sv
`timescale 1ns/1ps
`include "rv_consts.svh"

module rv_int_core (
    input  logic                   clk,
    input  logic                   rst,
    input  logic                   run,
    input  logic                   imem_we,
    input  logic [`RV_IMEM_AW-1:0] imem_addr,
    input  rv_isa_pkg::word_t      imem_wdata,
    output logic                   retire_valid,
    input  logic                   retire_ready,
    output rv_isa_pkg::word_t      retire_pc,
    output rv_isa_pkg::reg_addr_t  retire_rd,
    output rv_isa_pkg::word_t      retire_data
);
    import rv_isa_pkg::*;

    logic      advance;
    logic      redirect;
    word_t     redirect_pc;
    logic      if_valid;
    word_t     if_pc;
    word_t     if_instr;
    logic      fwd_en;
    reg_addr_t fwd_rd;
    word_t     fwd_data;
    logic      wb_en;
    reg_addr_t wb_rd;
    word_t     wb_data;

    id_ex_if dec_bus ();
    id_ex_if ex_bus ();

    fetch_stage u_fetch (
        .clk(clk), .rst(rst), .run(run), .advance(advance),
        .redirect(redirect), .redirect_pc(redirect_pc),
        .imem_we(imem_we), .imem_addr(imem_addr), .imem_wdata(imem_wdata),
        .if_valid(if_valid), .if_pc(if_pc), .if_instr(if_instr)
    );

    decode_stage u_decode (
        .clk(clk), .rst(rst), .advance(advance),
        .if_valid(if_valid), .if_pc(if_pc), .if_instr(if_instr),
        .fwd_en(fwd_en), .fwd_rd(fwd_rd), .fwd_data(fwd_data),
        .wb_en(wb_en), .wb_rd(wb_rd), .wb_data(wb_data),
        .dec_bus(dec_bus.producer)
    );

    id_ex_pipeline u_id_ex (
        .clk(clk), .rst(rst), .advance(advance), .redirect(redirect),
        .dec_bus(dec_bus.consumer), .ex_bus(ex_bus.producer)
    );

    execute_stage u_execute (
        .clk(clk), .rst(rst), .ex_bus(ex_bus.consumer),
        .redirect(redirect), .redirect_pc(redirect_pc),
        .fwd_en(fwd_en), .fwd_rd(fwd_rd), .fwd_data(fwd_data),
        .wb_en(wb_en), .wb_rd(wb_rd), .wb_data(wb_data),
        .advance(advance),
        .retire_valid(retire_valid), .retire_ready(retire_ready),
        .retire_pc(retire_pc), .retire_rd(retire_rd), .retire_data(retire_data)
    );

endmodule

//--- verification/retire_checker.sv
`timescale 1ns/1ps
`include "rv_consts.svh"

module retire_checker (
    input  logic                   clk,
    input  logic                   rst,
    input  logic                   run,
    input  logic                   imem_we,
    input  logic [`RV_IMEM_AW-1:0] imem_addr,
    input  rv_isa_pkg::word_t      imem_wdata,
    input  logic                   retire_valid,
    input  logic                   retire_ready,
    input  rv_isa_pkg::word_t      retire_pc,
    input  rv_isa_pkg::reg_addr_t  retire_rd,
    input  rv_isa_pkg::word_t      retire_data,
    output int                     total,
    output int                     retired,
    output int                     errors
);
    import rv_isa_pkg::*;

    localparam int STEP_LIMIT = 4096;

    word_t     mem [`RV_IMEM_WORDS];
    word_t     m_regs [`RV_NREGS];
    word_t     m_pc;
    logic      started;
    logic      waiting;
    word_t     held_pc;
    reg_addr_t held_rd;
    word_t     held_data;

    function automatic word_t alu(input logic [2:0] f3, input logic alt,
                                  input word_t x, input word_t y);
        word_t r;
        case (f3)
            3'd0: r = alt ? x - y : x + y;
            3'd1: r = x << y[4:0];
            3'd2: r = ($signed(x) < $signed(y)) ? 32'd1 : 32'd0;
            3'd3: r = (x < y) ? 32'd1 : 32'd0;
            3'd4: r = x ^ y;
            3'd5: begin
                if (alt) begin
                    r = $signed(x) >>> y[4:0];
                end else begin
                    r = x >> y[4:0];
                end
            end
            3'd6: r = x | y;
            default: r = x & y;
        endcase
        return r;
    endfunction

    function automatic logic branch_taken(input logic [2:0] f3, input word_t x, input word_t y);
        logic t;
        case (f3)
            3'd0: t = (x == y);
            3'd1: t = (x != y);
            3'd4: t = ($signed(x) < $signed(y));
            3'd5: t = ($signed(x) >= $signed(y));
            3'd6: t = (x < y);
            3'd7: t = (x >= y);
            default: t = 1'b0;
        endcase
        return t;
    endfunction

    // one architectural step from m_pc, giving the retire payload.
    function automatic void ref_step(output word_t pc_o, output reg_addr_t rd_o,
                                     output word_t data_o);
        word_t     instr;
        word_t     x;
        word_t     y;
        word_t     imm_i;
        word_t     next;
        word_t     val;
        logic      wr;
        reg_addr_t rd;
        instr = mem[m_pc[`RV_IMEM_AW+1:2]];
        rd    = instr[11:7];
        x     = m_regs[instr[19:15]];
        y     = m_regs[instr[24:20]];
        imm_i = {{20{instr[31]}}, instr[31:20]};
        next  = m_pc + 32'd4;
        val   = '0;
        wr    = 1'b1;
        case (instr[6:0])
            7'b0110011: val = alu(instr[14:12], instr[30], x, y);
            7'b0010011: val = alu(instr[14:12], instr[14:12] == 3'd5 && instr[30], x, imm_i);
            7'b0110111: val = {instr[31:12], 12'b0};
            7'b0010111: val = m_pc + {instr[31:12], 12'b0};
            7'b1101111: begin
                val  = m_pc + 32'd4;
                next = m_pc + {{12{instr[31]}}, instr[19:12], instr[20], instr[30:21], 1'b0};
            end
            7'b1100111: begin
                val  = m_pc + 32'd4;
                next = (x + imm_i) & ~32'd1;
            end
            7'b1100011: begin
                wr = 1'b0;
                if (branch_taken(instr[14:12], x, y)) begin
                    next = m_pc + {{20{instr[31]}}, instr[7], instr[30:25], instr[11:8], 1'b0};
                end
            end
            default: wr = 1'b0;
        endcase
        if (!wr || rd == 5'd0) begin
            rd  = '0;
            val = '0;
        end else begin
            m_regs[rd] = val;
        end
        pc_o   = m_pc;
        rd_o   = rd;
        data_o = val;
        m_pc   = next;
    endfunction

    function automatic void reset_model();
        m_pc = '0;
        for (int i = 0; i < `RV_NREGS; i++) begin
            m_regs[i] = '0;
        end
    endfunction

    // retirements up to and including the first self-jump.
    function automatic int count_to_end();
        word_t     p;
        reg_addr_t r;
        word_t     d;
        int        n;
        logic      done;
        reset_model();
        n    = 0;
        done = 1'b0;
        while (!done) begin
            ref_step(p, r, d);
            n++;
            done = (m_pc == p) || (n >= STEP_LIMIT);
        end
        reset_model();
        return n;
    endfunction

    always @(posedge clk) begin : compare
        word_t     e_pc;
        reg_addr_t e_rd;
        word_t     e_data;
        if (rst) begin
            started = 1'b0;
            waiting = 1'b0;
            total   = 0;
            retired = 0;
            errors  = 0;
        end else begin
            if (imem_we && !run) begin
                mem[imem_addr] = imem_wdata;
            end
            if (!run && retire_valid) begin
                $display("FAIL %0t: retire_valid high while run is low", $time);
                errors++;
            end
            if (run && !started) begin
                started = 1'b1;
                total   = count_to_end();
                if (total >= STEP_LIMIT) begin
                    $display("ERROR: reference model never reached the final self-jump");
                    errors++;
                end
            end
            if (waiting && (!retire_valid || retire_pc != held_pc ||
                            retire_rd != held_rd || retire_data != held_data)) begin
                $display("FAIL %0t: retire payload changed before ready", $time);
                errors++;
            end
            if (retire_valid && retire_ready) begin
                ref_step(e_pc, e_rd, e_data);
                retired++;
                if (retire_pc != e_pc) begin
                    $display("FAIL %0t: retired pc %h, expected %h", $time, retire_pc, e_pc);
                    errors++;
                end else if (retire_rd != e_rd || retire_data != e_data) begin
                    $display("FAIL %0t: pc %h wrote x%0d=%h, expected x%0d=%h", $time,
                             retire_pc, retire_rd, retire_data, e_rd, e_data);
                    errors++;
                end
            end
            waiting   = retire_valid && !retire_ready;
            held_pc   = retire_pc;
            held_rd   = retire_rd;
            held_data = retire_data;
        end
    end

endmodule

//--- verification/tb_rv_int_core.sv
`timescale 1ns/1ps
`include "rv_consts.svh"

module tb_rv_int_core;
    import rv_isa_pkg::*;

    localparam int CLK_NS = 4;
    localparam logic [6:0] OPC_IMM   = 7'b0010011;
    localparam logic [6:0] OPC_UI    = 7'b0110111;
    localparam logic [6:0] OPC_AUIPC = 7'b0010111;
    localparam logic [6:0] OPC_JALR  = 7'b1100111;

    logic                   clk;
    logic                   rst;
    logic                   run;
    logic                   imem_we;
    logic [`RV_IMEM_AW-1:0] imem_addr;
    word_t                  imem_wdata;
    logic                   retire_valid;
    logic                   retire_ready;
    word_t                  retire_pc;
    reg_addr_t              retire_rd;
    word_t                  retire_data;
    int                     total;
    int                     retired;
    int                     errors;
    logic                   go;
    integer                 seed = 32'h43b193ba;
    word_t                  prog [`RV_IMEM_WORDS];
    int                     wp;

    rv_int_core DUT (
        .clk(clk), .rst(rst), .run(run),
        .imem_we(imem_we), .imem_addr(imem_addr), .imem_wdata(imem_wdata),
        .retire_valid(retire_valid), .retire_ready(retire_ready),
        .retire_pc(retire_pc), .retire_rd(retire_rd), .retire_data(retire_data)
    );

    retire_checker chk (
        .clk(clk), .rst(rst), .run(run),
        .imem_we(imem_we), .imem_addr(imem_addr), .imem_wdata(imem_wdata),
        .retire_valid(retire_valid), .retire_ready(retire_ready),
        .retire_pc(retire_pc), .retire_rd(retire_rd), .retire_data(retire_data),
        .total(total), .retired(retired), .errors(errors)
    );

    function automatic int rnd(input int n);
        return int'($unsigned($random(seed)) % n);
    endfunction

    function automatic word_t enc_r(input int f7, input int rs2, input int rs1,
                                    input int f3, input int rd);
        return {f7[6:0], rs2[4:0], rs1[4:0], f3[2:0], rd[4:0], 7'b0110011};
    endfunction

    function automatic word_t enc_i(input int imm, input int rs1, input int f3,
                                    input int rd, input logic [6:0] op);
        return {imm[11:0], rs1[4:0], f3[2:0], rd[4:0], op};
    endfunction

    function automatic word_t enc_u(input int imm, input int rd, input logic [6:0] op);
        return {imm[19:0], rd[4:0], op};
    endfunction

    function automatic word_t enc_j(input int off, input int rd);
        return {off[20], off[10:1], off[11], off[19:12], rd[4:0], 7'b1101111};
    endfunction

    function automatic word_t enc_b(input int off, input int rs2, input int rs1, input int f3);
        return {off[12], off[10:5], rs2[4:0], rs1[4:0], f3[2:0], off[4:1], off[11], 7'b1100011};
    endfunction

    task automatic emit(input word_t w);
        prog[wp] = w;
        wp++;
    endtask

    // random alu or upper-immediate op on x0 and x5..x15.
    task automatic emit_filler();
        int sel;
        int rd;
        int rs1;
        int rs2;
        int f3;
        int f7;
        int imm;
        sel = rnd(8);
        rd  = rnd(12);
        if (rd != 0) begin
            rd = rd + 4;
        end
        rs1 = rnd(16);
        rs2 = rnd(16);
        f3  = rnd(8);
        imm = rnd(4096);
        if (f3 == 1 || f3 == 5) begin
            imm = (f3 == 5 && rnd(2) == 1) ? (32'h400 | rnd(32)) : rnd(32);
        end
        if (sel < 4) begin
            f7 = ((f3 == 0 || f3 == 5) && rnd(2) == 1) ? 32 : 0;
            emit(enc_r(f7, rs2, rs1, f3, rd));
        end else if (sel < 6) begin
            emit(enc_i(imm, rs1, f3, rd, OPC_IMM));
        end else if (sel == 6) begin
            emit(enc_u(rnd(1 << 20), rd, OPC_UI));
        end else begin
            emit(enc_u(rnd(1 << 20), rd, OPC_AUIPC));
        end
    endtask

    task automatic build_program();
        int loop_at;
        int a;
        int b;
        // unused words are nops tagged with their address.
        for (int i = 0; i < `RV_IMEM_WORDS; i++) begin
            prog[i] = enc_i(i, 0, 0, 0, OPC_IMM);
        end
        wp = 0;
        repeat (4) emit_filler();
        // countdown loop on x20.
        emit(enc_i(5, 0, 0, 20, OPC_IMM));
        loop_at = wp;
        repeat (2) emit_filler();
        emit(enc_i(-1, 20, 0, 20, OPC_IMM));
        emit(enc_b((loop_at - wp) * 4, 0, 20, 1));
        // call through x1, hop over the callee on return.
        emit(enc_j(8, 1));
        emit(enc_j(12, 0));
        emit_filler();
        emit(enc_i(0, 1, 0, 3, OPC_JALR));
        // x21 equal, signed below, then unsigned below x22.
        for (int s = 0; s < 3; s++) begin
            a = rnd(1000) + 1;
            b = (s == 2) ? a + 1 + rnd(500) : a;
            if (s == 1) begin
                a = -a;
            end
            emit(enc_i(a, 0, 0, 21, OPC_IMM));
            emit(enc_i(b, 0, 0, 22, OPC_IMM));
            for (int k = 0; k < 6; k++) begin
                emit(enc_b(8, 22, 21, (k < 2) ? k : k + 2));
                emit_filler();
            end
        end
        repeat (6) emit_filler();
        emit(enc_j(0, 0));
    endtask

    initial begin : clock_gen
        clk = 1'b0;
        forever #(CLK_NS / 2) clk = ~clk;
    end

    initial begin : ready_driver
        retire_ready = 1'b0;
        forever begin
            @(posedge clk);
            #1;
            retire_ready = (rnd(10) < 7);
        end
    end

    initial begin : watchdog
        wait (go);
        #((total * 8 + 200) * CLK_NS);
        $display("ERROR: timeout, only %0d of %0d instructions retired", retired, total);
        $display("Test failed");
        $finish;
    end

    initial begin : main
        rst        = 1'b1;
        run        = 1'b0;
        imem_we    = 1'b0;
        imem_addr  = '0;
        imem_wdata = '0;
        go         = 1'b0;
        build_program();
        repeat (2) @(posedge clk);
        #1;
        rst = 1'b0;
        for (int i = 0; i < `RV_IMEM_WORDS; i++) begin
            imem_we    = 1'b1;
            imem_addr  = i[`RV_IMEM_AW-1:0];
            imem_wdata = prog[i];
            @(posedge clk);
            #1;
        end
        imem_we = 1'b0;
        run     = 1'b1;
        @(posedge clk);
        #1;
        go = 1'b1;
        while (retired < total) begin
            @(posedge clk);
            #1;
        end
        repeat (4) @(posedge clk);
        #1;
        $display("errors %0d, retired %0d of %0d", errors, retired, total);
        if (errors == 0) begin
            $display("Test completed successfully");
        end else begin
            $display("Test failed");
        end
        $finish;
    end

endmodule

//--- filelist.f
+incdir+src
src/rv_isa_pkg.sv
src/rv_pipe_pkg.sv
src/id_ex_if.sv
src/fetch_stage.sv
src/decode_stage.sv
src/id_ex_pipeline.sv
src/execute_stage.sv
src/rv_int_core.sv
verification/retire_checker.sv
verification/tb_rv_int_core.sv

//--- run_sim.sh
#!/bin/sh
cd "$(dirname "$0")" || exit 1

verilator --binary --timing -f filelist.f --top-module tb_rv_int_core \
    -Mdir obj_dir -o sim_tb
if [ $? -ne 0 ]; then
    echo "verilator build failed"
    exit 1
fi

out=$(./obj_dir/sim_tb)
status=$?
echo "$out"
if [ $status -ne 0 ]; then
    echo "simulation exited with status $status"
    exit 1
fi

if echo "$out" | grep -qx "Test completed successfully"; then
    exit 0
fi
exit 1
